// File: mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

////////////////////////////// 
// Opcodes
//////////////////////////////

`define OP_RT      6'b000000
`define OP_BGEZ    6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111

////////////////////////////// 
// Function and rt codes
//////////////////////////////

`define F_JR       6'b001000
`define F_JALR     6'b001001

// Linking forms of the REGIMM group.
`define B_BLTZAL   5'b10000
`define B_BGEZAL   5'b10001

// Return address register.
`define REG_RA     5'd31

////////////////////////////// 
// Table and stack sizes
//////////////////////////////

`define JR_ENTRY_WIDTH   2
`define RAS_DEPTH        (1 << `JR_ENTRY_WIDTH)

`define BPB_INDEX_WIDTH  6
`define BPB_DEPTH        (1 << `BPB_INDEX_WIDTH)

`endif

// File: mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

    // Basic machine words and instruction fields.
    typedef logic [31:0] word_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;

    // Predictor table index and stack pointer.
    typedef logic [`BPB_INDEX_WIDTH-1:0] bpb_index_t;
    typedef logic [`JR_ENTRY_WIDTH-1:0]  ras_ptr_t;

    //////////////////////////////
    // Prediction and resolve
    //////////////////////////////

    // Used both for the raw counter lookup and the final prediction.
    typedef struct packed {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

    // Branch outcome reported back from execute.
    typedef struct packed {
        word_t pc;
        logic  taken;
    } resolve_t;

endpackage

// File: bpb_counters.sv
`timescale 1ns/1ps

`include "mips_consts.svh"

module bpb_counters (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mips_pkg::word_t       fetch_pc,
    input  logic                  resolve_valid,
    input  mips_pkg::resolve_t    resolve,
    output mips_pkg::bpb_result_t counter_pred
);

    logic [1:0]           counters [`BPB_DEPTH];
    mips_pkg::bpb_index_t fetch_idx;
    mips_pkg::bpb_index_t resolve_idx;
    logic [1:0]           cur;

    // Word-aligned pc, so the index starts at bit 2.
    assign fetch_idx   = fetch_pc[`BPB_INDEX_WIDTH+1:2];
    assign resolve_idx = resolve.pc[`BPB_INDEX_WIDTH+1:2];

    //////////////////////////////
    // Lookup
    //////////////////////////////

    // The high bit of the counter is the prediction.
    assign counter_pred.taken  = counters[fetch_idx][1];
    assign counter_pred.destpc = '0;

    //////////////////////////////
    // Training
    //////////////////////////////

    assign cur = counters[resolve_idx];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Weakly not taken.
            for (int i = 0; i < `BPB_DEPTH; i++)
                counters[i] <= 2'b01;
        end
        else if (resolve_valid)
        begin
            if (resolve.taken)
            begin
                if (cur != 2'b11)
                    counters[resolve_idx] <= cur + 2'b01;
            end
            else
            begin
                if (cur != 2'b00)
                    counters[resolve_idx] <= cur - 2'b01;
            end
        end
    end

    // Execute must report the pc of a real instruction.
    a_resolve_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        resolve_valid |-> (resolve.pc[1:0] == 2'b00)
    );

endmodule

// File: ras.sv
`timescale 1ns/1ps

`include "mips_consts.svh"

module ras (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_valid,
    input  logic               push,
    input  mips_pkg::word_t    push_addr,
    input  mips_pkg::ras_ptr_t next_ptr,
    output mips_pkg::word_t    top_addr,
    output mips_pkg::ras_ptr_t top_ptr
);

    mips_pkg::word_t    entries [`RAS_DEPTH];
    mips_pkg::ras_ptr_t ptr;
    mips_pkg::ras_ptr_t ptr_step;

    assign top_addr = entries[ptr];
    assign top_ptr  = ptr;

    //////////////////////////////
    // Stack update
    //////////////////////////////

    // The decoder has already worked out where the pointer goes, so a push
    // lands at next_ptr. With push and pop together that is the current top.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ptr <= '0;
            for (int i = 0; i < `RAS_DEPTH; i++)
                entries[i] <= '0;
        end
        else if (fetch_valid)
        begin
            ptr <= next_ptr;
            if (push)
                entries[next_ptr] <= push_addr;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Pointer moves by at most one entry, modulo the depth.
    assign ptr_step = next_ptr - ptr;

    a_ptr_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_valid |-> (ptr_step == 2'd0 || ptr_step == 2'd1 || ptr_step == '1)
    );

    // A push with no pointer change only happens when a pop cancels it,
    // so the overwritten slot is the live top.
    a_push_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fetch_valid && push) |-> (ptr_step != '1)
    );

endmodule

// File: bpbdecode.sv
`timescale 1ns/1ps

`include "mips_consts.svh"

module bpbdecode (
    input  mips_pkg::word_t       pc,
    input  mips_pkg::word_t       instr,
    input  mips_pkg::bpb_result_t in,
    input  mips_pkg::word_t       jr_destpc,
    input  mips_pkg::ras_ptr_t    jr_top_in,
    output mips_pkg::bpb_result_t out,
    output logic                  jr_push,
    output logic                  jr_pop,
    output mips_pkg::word_t       ret_addr,
    output mips_pkg::ras_ptr_t    jr_top_out
);

    mips_pkg::op_t   op;
    mips_pkg::func_t func;
    logic [4:0]      rs;
    logic [4:0]      rt;
    logic            jr_func;
    logic            j_pc;
    logic            b_pc;
    logic            jr_pc;
    mips_pkg::word_t pcplus4;
    mips_pkg::word_t ext_imm;
    mips_pkg::word_t pcjump;
    mips_pkg::word_t pcbranch;

    assign op      = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign func    = instr[5:0];
    assign jr_func = (func == `F_JR) || (func == `F_JALR);

    //////////////////////////////
    // Classify
    //////////////////////////////

    // Each class comes from its own opcode compare.
    assign j_pc  = (op == `OP_J) || (op == `OP_JAL);
    assign b_pc  = (op == `OP_BEQ) || (op == `OP_BNE) || (op == `OP_BGTZ) ||
                   (op == `OP_BLEZ) || (op == `OP_BGEZ);
    assign jr_pc = (op == `OP_RT) && jr_func;

    // Calls push pc plus 8, and register jumps through $31 pop.
    assign jr_push = (op == `OP_JAL) ||
                     ((op == `OP_BGEZ) && ((rt == `B_BGEZAL) || (rt == `B_BLTZAL))) ||
                     (jr_pc && (func == `F_JALR));
    assign jr_pop  = jr_pc && (rs == `REG_RA);

    //////////////////////////////
    // Targets
    //////////////////////////////

    assign pcplus4  = pc + 32'd4;
    assign ret_addr = pc + 32'd8;     // skip the delay slot
    assign ext_imm  = {{16{instr[15]}}, instr[15:0]};
    assign pcbranch = pcplus4 + {ext_imm[29:0], 2'b00};
    assign pcjump   = {pcplus4[31:28], instr[25:0], 2'b00};

    assign out.taken  = (in.taken & b_pc) | j_pc | jr_pc;
    assign out.destpc = j_pc  ? pcjump :
                        b_pc  ? pcbranch :
                        jr_pc ? jr_destpc : '0;

    // Push and pop together leave the pointer where it is.
    always_comb
    begin
        case ({jr_push, jr_pop})
            2'b10:   jr_top_out = jr_top_in + 1'b1;
            2'b01:   jr_top_out = jr_top_in - 1'b1;
            default: jr_top_out = jr_top_in;
        endcase
    end

    a_one_class: assert final ($onehot0({j_pc, b_pc, jr_pc}));

endmodule

// File: bp_frontend.sv
`timescale 1ns/1ps

module bp_frontend (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  mips_pkg::word_t       fetch_pc,
    input  mips_pkg::word_t       fetch_instr,
    input  logic                  resolve_valid,
    input  mips_pkg::resolve_t    resolve,
    output logic                  pred_valid,
    output mips_pkg::bpb_result_t pred
);

    mips_pkg::bpb_result_t counter_pred;
    mips_pkg::word_t       top_addr;
    mips_pkg::ras_ptr_t    top_ptr;
    mips_pkg::ras_ptr_t    next_ptr;
    mips_pkg::word_t       ret_addr;
    logic                  push;

    // Prediction is purely combinational on the fetch inputs.
    assign pred_valid = fetch_valid;

    bpb_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_pc      (fetch_pc),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .counter_pred  (counter_pred)
    );

    ras u_ras (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .push        (push),
        .push_addr   (ret_addr),
        .next_ptr    (next_ptr),
        .top_addr    (top_addr),
        .top_ptr     (top_ptr)
    );

    // The pop is already folded into next_ptr.
    bpbdecode u_decode (
        .pc         (fetch_pc),
        .instr      (fetch_instr),
        .in         (counter_pred),
        .jr_destpc  (top_addr),
        .jr_top_in  (top_ptr),
        .out        (pred),
        .jr_push    (push),
        .jr_pop     (),
        .ret_addr   (ret_addr),
        .jr_top_out (next_ptr)
    );

endmodule

// File: bp_tb.sv
`timescale 1ns/1ps

`include "mips_consts.svh"

module bp_tb;

    logic                  clk;
    logic                  rst_n;
    logic                  fetch_valid;
    mips_pkg::word_t       fetch_pc;
    mips_pkg::word_t       fetch_instr;
    logic                  resolve_valid;
    mips_pkg::resolve_t    resolve;
    logic                  pred_valid;
    mips_pkg::bpb_result_t pred;

    integer seed;

    // Reference state of the predictor.
    logic [1:0]         model_cnt [`BPB_DEPTH];
    mips_pkg::word_t    model_ras [`RAS_DEPTH];
    mips_pkg::ras_ptr_t model_ptr;

    string test_name;
    int    test_errors;
    int    test_checks;
    int    total_errors;
    int    total_checks;
    int    tests_run;
    int    tests_failed;

    bp_frontend uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_instr   (fetch_instr),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .pred_valid    (pred_valid),
        .pred          (pred)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Small pc range so that table indices repeat, with a varying region nibble.
    function automatic mips_pkg::word_t rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:28], 18'h0, r[7:0], 2'b00};
    endfunction

    function automatic mips_pkg::word_t reg_jump(input logic [4:0] rs, input logic link);
        if (link)
            return {`OP_RT, rs, 5'd0, 5'd31, 5'd0, `F_JALR};
        return {`OP_RT, rs, 15'h0, `F_JR};
    endfunction

    // Kinds: 0 J, 1 JAL, 2 branch, 3 linking branch, 4 JR, 5 JALR, 6 ALU, 7 memory.
    function automatic mips_pkg::word_t make_instr(input int kind);
        logic [31:0] r;
        logic [4:0]  rs;
        r  = $random(seed);
        rs = r[26] ? `REG_RA : r[25:21];
        case (kind)
            0: return {`OP_J, r[25:0]};
            1: return {`OP_JAL, r[25:0]};
            2:
                case (r[29:27])
                    0: return {`OP_BEQ, r[25:0]};
                    1: return {`OP_BNE, r[25:0]};
                    2: return {`OP_BGTZ, r[25:0]};
                    3: return {`OP_BLEZ, r[25:0]};
                    default: return {`OP_BGEZ, r[25:21], 4'b0000, r[16], r[15:0]};
                endcase
            3: return {`OP_BGEZ, r[25:21], r[16] ? `B_BGEZAL : `B_BLTZAL, r[15:0]};
            4: return reg_jump(rs, 1'b0);
            5: return reg_jump(rs, 1'b1);
            6: return {`OP_RT, r[25:6], 3'b100, r[2:0]};
            default: return {r[27] ? 6'h23 : 6'h2b, r[25:0]};
        endcase
    endfunction

    function automatic int rand_kind();
        int r;
        r = $unsigned($random(seed)) % 16;
        if (r == 0) return 0;
        if (r == 1) return 1;
        if (r < 6) return 2;
        if (r < 8) return 3;
        if (r < 10) return 4;
        if (r == 10) return 5;
        if (r < 14) return 6;
        return 7;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic void model_predict(input mips_pkg::word_t pc, input mips_pkg::word_t instr,
            output logic taken, output mips_pkg::word_t dest, output logic push, output logic pop);
        mips_pkg::word_t pc4;
        mips_pkg::word_t offset;
        logic            reg_jump_fn;
        pc4         = pc + 32'd4;
        offset      = {{14{instr[15]}}, instr[15:0], 2'b00};
        reg_jump_fn = (instr[5:0] == `F_JR) || (instr[5:0] == `F_JALR);
        taken       = 1'b0;
        dest        = '0;
        push        = 1'b0;
        pop         = 1'b0;
        case (instr[31:26])
            `OP_J, `OP_JAL:
            begin
                taken = 1'b1;
                dest  = {pc4[31:28], instr[25:0], 2'b00};
                push  = (instr[31:26] == `OP_JAL);
            end
            `OP_BEQ, `OP_BNE, `OP_BGTZ, `OP_BLEZ, `OP_BGEZ:
            begin
                taken = (model_cnt[pc[`BPB_INDEX_WIDTH+1:2]] >= 2'd2);
                dest  = pc4 + offset;
                push  = (instr[31:26] == `OP_BGEZ) &&
                        ((instr[20:16] == `B_BGEZAL) || (instr[20:16] == `B_BLTZAL));
            end
            `OP_RT:
                if (reg_jump_fn)
                begin
                    taken = 1'b1;
                    dest  = model_ras[model_ptr];
                    pop   = (instr[25:21] == `REG_RA);
                    push  = (instr[5:0] == `F_JALR);
                end
            default:
                taken = 1'b0;
        endcase
    endfunction

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    // Compares the stable outputs, then advances the model by what was driven.
    task automatic check_cycle();
        logic                 exp_taken;
        mips_pkg::word_t      exp_dest;
        logic                 push;
        logic                 pop;
        mips_pkg::bpb_index_t idx;
        model_predict(fetch_pc, fetch_instr, exp_taken, exp_dest, push, pop);
        test_checks++;
        total_checks++;
        assert (pred_valid === fetch_valid) else
        begin
            $display("ERROR %s: pred_valid expected %0b actual %0b",
                     test_name, fetch_valid, pred_valid);
            count_error();
        end
        if (fetch_valid)
        begin
            assert (pred.taken === exp_taken) else
            begin
                $display("ERROR %s: taken expected %0b actual %0b",
                         test_name, exp_taken, pred.taken);
                count_error();
            end
            assert (pred.destpc === exp_dest) else
            begin
                $display("ERROR %s: destpc expected %h actual %h",
                         test_name, exp_dest, pred.destpc);
                count_error();
            end
            if (push && !pop)
            begin
                model_ptr            = model_ptr + 1'b1;
                model_ras[model_ptr] = fetch_pc + 32'd8;
            end
            else if (pop && !push)
                model_ptr = model_ptr - 1'b1;
            else if (push && pop)
                model_ras[model_ptr] = fetch_pc + 32'd8;
        end
        if (resolve_valid)
        begin
            idx = resolve.pc[`BPB_INDEX_WIDTH+1:2];
            if (resolve.taken && model_cnt[idx] != 2'd3)
                model_cnt[idx] = model_cnt[idx] + 2'd1;
            else if (!resolve.taken && model_cnt[idx] != 2'd0)
                model_cnt[idx] = model_cnt[idx] - 2'd1;
        end
    endtask

    task automatic step(input logic fv, input mips_pkg::word_t pc, input mips_pkg::word_t instr,
            input logic rv, input mips_pkg::word_t rpc, input logic rtk);
        @(posedge clk);
        fetch_valid   <= fv;
        fetch_pc      <= pc;
        fetch_instr   <= instr;
        resolve_valid <= rv;
        resolve       <= {rpc, rtk};
        @(negedge clk);
        check_cycle();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("%-14s %s  checks=%0d errors=%0d", test_name,
                 (test_errors == 0) ? "passed" : "FAILED", test_checks, test_errors);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        mips_pkg::word_t pc;
        mips_pkg::word_t instr;
        logic [31:0]     r;
        seed          = 32'h673f7828;
        clk           = 1'b0;
        rst_n         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        fetch_instr   = '0;
        resolve_valid = 1'b0;
        resolve       = '0;
        model_ptr     = '0;
        total_errors  = 0;
        total_checks  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int i = 0; i < `BPB_DEPTH; i++)
            model_cnt[i] = 2'b01;
        for (int i = 0; i < `RAS_DEPTH; i++)
            model_ras[i] = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_check");
        @(negedge clk);
        test_checks++;
        total_checks++;
        assert (pred_valid === 1'b0) else
        begin
            $display("ERROR %s: pred_valid expected 0 actual %0b", test_name, pred_valid);
            count_error();
        end
        repeat (8) step(1'b1, rand_pc(), make_instr(2), 1'b0, '0, 1'b0);
        finish_test();

        start_test("jump_test");
        for (int i = 0; i < 20; i++)
            step(1'b1, rand_pc(), make_instr(i % 2), 1'b0, '0, 1'b0);
        finish_test();

        // Drive each counter up to saturation and back down to zero.
        start_test("branch_train");
        for (int t = 0; t < 4; t++)
        begin
            pc    = rand_pc();
            instr = make_instr(2);
            repeat (5) step(1'b1, pc, instr, 1'b1, pc, 1'b1);
            repeat (5) step(1'b1, pc, instr, 1'b1, pc, 1'b0);
            step(1'b1, pc, instr, 1'b0, '0, 1'b0);
        end
        finish_test();

        start_test("ras_nesting");
        for (int i = 0; i < 6; i++)
            step(1'b1, rand_pc(), make_instr((i % 2) ? 1 : 3), 1'b0, '0, 1'b0);
        repeat (6) step(1'b1, rand_pc(), reg_jump(`REG_RA, 1'b0), 1'b0, '0, 1'b0);
        finish_test();

        start_test("jalr_jr_other");
        repeat (3)
        begin
            step(1'b1, rand_pc(), make_instr(1), 1'b0, '0, 1'b0);
            step(1'b1, rand_pc(), reg_jump(`REG_RA, 1'b1), 1'b0, '0, 1'b0);
            step(1'b1, rand_pc(), reg_jump(5'd5, 1'b0), 1'b0, '0, 1'b0);
            step(1'b1, rand_pc(), reg_jump(`REG_RA, 1'b0), 1'b0, '0, 1'b0);
        end
        finish_test();

        start_test("alu_test");
        step(1'b1, rand_pc(), make_instr(1), 1'b0, '0, 1'b0);
        for (int i = 0; i < 20; i++)
            step(1'b1, rand_pc(), make_instr(6 + (i % 2)), 1'b0, '0, 1'b0);
        step(1'b1, rand_pc(), reg_jump(`REG_RA, 1'b0), 1'b0, '0, 1'b0);
        finish_test();

        start_test("random_mix");
        repeat (2000)
        begin
            r = $random(seed);
            step(r[2:0] != 3'd0, rand_pc(), make_instr(rand_kind()),
                 r[4:3] == 2'd0, rand_pc(), r[5]);
        end
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Watchdog against a stalled run.
    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < 5000)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Simulation timed out after %0d cycles", cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
mips_pkg.sv
bpb_counters.sv
ras.sv
bpbdecode.sv
bp_frontend.sv
bp_tb.sv
